// ==== verilog/seg_pkg.sv ====
//################################################
// seven-segment display shared definitions
// opcode enum, command field widths, digit count
// and the hex to segment pattern table
//################################################
package seg_pkg;

	// number of multiplexed digits on the board
	localparam int DIGITS = 8;

	// command field widths
	localparam int OP_W = 2;
	localparam int DIG_W = 3;
	localparam int VAL_W = 4;

	// packed command is {op, digit, value}, value in the low bits
	localparam int CMD_W = OP_W + DIG_W + VAL_W;

	// host command opcodes
	typedef enum logic [OP_W-1:0] {
		// load a hex value into one digit and light it
		op_write = 2'd0,
		// turn one digit off, value kept
		op_blank = 2'd1,
		// all digits off, all values back to zero
		op_clear_all = 2'd2
	} seg_op_e;

	// active-low common-anode patterns, bit 7 is the decimal point (kept off)
	localparam logic [7:0] seg_code [16] = '{
		// 0 .. 3
		8'hC0, 8'hF9, 8'hA4, 8'hB0,
		// 4 .. 7
		8'h99, 8'h92, 8'h82, 8'hF8,
		// 8 .. b
		8'h80, 8'h90, 8'h88, 8'h83,
		// c .. f
		8'hA7, 8'hA1, 8'h84, 8'h8E
	};

endpackage

// ==== verilog/seg_cmd_source.sv ====
`timescale 1ns/1ps
//################################################
// host command source
// holds one accepted command and hands it to the
// FIFO as a push while credits remain
//################################################
module seg_cmd_source #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        cmd_valid,
	input  seg_pkg::seg_op_e            cmd_op,
	input  logic [seg_pkg::DIG_W-1:0]   cmd_digit,
	input  logic [seg_pkg::VAL_W-1:0]   cmd_value,
	input  logic                        credit_return,
	output logic                        cmd_ready,
	output logic                        push,
	output logic [seg_pkg::CMD_W-1:0]   push_cmd
);

	// counter must reach FIFO_DEPTH itself
	localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

	// one command deep output register
	logic hold_valid;
	logic [seg_pkg::CMD_W-1:0] hold_cmd;

	// free FIFO slots as seen from this side
	logic [CRD_W-1:0] credit_cnt;

	// handshake completes this cycle
	logic accept;

	// held command leaves as soon as a slot is free
	assign push = hold_valid && (credit_cnt != '0);
	assign push_cmd = hold_cmd;

	// room if empty or if the held entry goes out on this same edge
	assign cmd_ready = !hold_valid || push;
	assign accept = cmd_valid && cmd_ready;

	// valid flag of the output register
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			hold_valid <= 1'b0;
		end else if (accept) begin
			// new command replaces the one pushed out this cycle
			hold_valid <= 1'b1;
		end else if (push) begin
			hold_valid <= 1'b0;
		end
	end

	// command payload is only meaningful while hold_valid
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			hold_cmd <= {cmd_op, cmd_digit, cmd_value};
		end
	end

	// credit arithmetic
	// push spends one and a return from the scanner gives one back
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			// buffer starts empty so every slot is a credit
			credit_cnt <= CRD_W'(FIFO_DEPTH);
		end else begin
			case ({push, credit_return})
				2'b10: credit_cnt <= credit_cnt - CRD_W'(1);
				2'b01: credit_cnt <= credit_cnt + CRD_W'(1);
				// count holds for both or neither
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// never push without a credit in hand
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		push |-> (credit_cnt != '0));

	// returns from the scanner never exceed what was spent
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		credit_cnt <= CRD_W'(FIFO_DEPTH));

endmodule

// ==== verilog/seg_cmd_fifo.sv ====
`timescale 1ns/1ps
//################################################
// command FIFO
// circular buffer sized to the credit count, sits
// between the command source and the scanner
//################################################
module seg_cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        push,
	input  logic [seg_pkg::CMD_W-1:0]   push_cmd,
	input  logic                        pop,
	output logic [seg_pkg::CMD_W-1:0]   pop_cmd,
	output logic                        not_empty
);

	// pointer needs at least one bit even for a single entry
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// storage
	logic [seg_pkg::CMD_W-1:0] mem [FIFO_DEPTH];

	// read side and write side pointers
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// entries currently held
	logic [CNT_W-1:0] count;

	// step a pointer with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	// write port
	always_ff @(posedge sys_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// pointers advance on their own strobes
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
		end
	end

	// occupancy
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	// head of queue is shown directly, the scanner takes it on pop
	assign pop_cmd = mem[rd_ptr];
	assign not_empty = (count != '0);

	// the credit loop in the source keeps a full buffer from being pushed
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		push |-> (count != CNT_W'(FIFO_DEPTH)));

	// scanner only pops what is there
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		pop |-> (count != '0));

endmodule

// ==== verilog/seg_scan_driver.sv ====
`timescale 1ns/1ps
//################################################
// scanning display driver
// applies popped commands to the digit registers
// and multiplexes the digits onto active-low outputs
//################################################
module seg_scan_driver #(
	parameter int REFRESH_DIV = 50000
) (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic [seg_pkg::CMD_W-1:0]     pop_cmd,
	input  logic                          not_empty,
	output logic                          pop,
	output logic                          credit_return,
	output logic [7:0]                    seg_val_out,
	output logic [seg_pkg::DIGITS-1:0]    seg_sel_out
);

	// refresh divider width of at least one bit
	localparam int DIV_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

	// fields of the command at the FIFO head
	seg_pkg::seg_op_e pop_op;
	logic [seg_pkg::DIG_W-1:0] pop_digit;
	logic [seg_pkg::VAL_W-1:0] pop_value;

	// per digit hex value and enable flag
	logic [seg_pkg::VAL_W-1:0] dig_val [seg_pkg::DIGITS];
	logic [seg_pkg::DIGITS-1:0] dig_en;

	// refresh tick counter and current digit
	logic [DIV_W-1:0] div_cnt;
	logic [seg_pkg::DIG_W-1:0] sel;

	// unpack {op, digit, value}
	assign pop_op = seg_pkg::seg_op_e'(pop_cmd[seg_pkg::CMD_W-1 -: seg_pkg::OP_W]);
	assign pop_digit = pop_cmd[seg_pkg::VAL_W +: seg_pkg::DIG_W];
	assign pop_value = pop_cmd[seg_pkg::VAL_W-1:0];

	// one command per cycle is applied on the pop edge
	assign pop = not_empty;

	// credit goes back to the source one cycle after the pop
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

	// enable flags
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			// everything dark out of reset
			dig_en <= '0;
		end else if (pop) begin
			case (pop_op)
				seg_pkg::op_write: dig_en[pop_digit] <= 1'b1;
				seg_pkg::op_blank: dig_en[pop_digit] <= 1'b0;
				seg_pkg::op_clear_all: dig_en <= '0;
				// unused opcode is ignored
				default: dig_en <= dig_en;
			endcase
		end
	end

	// digit values
	// blank leaves the value alone so a later write only needs the new digit
	always_ff @(posedge sys_clk) begin
		if (pop) begin
			case (pop_op)
				seg_pkg::op_write: dig_val[pop_digit] <= pop_value;
				seg_pkg::op_clear_all: begin
					for (int i = 0; i < seg_pkg::DIGITS; i++) begin
						dig_val[i] <= '0;
					end
				end
				default: ;
			endcase
		end
	end

	// refresh timing
	// sel steps once every REFRESH_DIV clocks and wraps after the last digit
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
			sel <= '0;
		end else if (div_cnt == DIV_W'(REFRESH_DIV - 1)) begin
			div_cnt <= '0;
			sel <= sel + seg_pkg::DIG_W'(1);
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// digit select is low only on the scanned digit and only if lit
	genvar g;
	generate
		for (g = 0; g < seg_pkg::DIGITS; g++) begin : gen_sel
			assign seg_sel_out[g] = ~((sel == seg_pkg::DIG_W'(g)) && dig_en[g]);
		end
	endgenerate

	// segment pattern of the scanned digit
	assign seg_val_out = seg_pkg::seg_code[dig_val[sel]];

	// never more than one digit driven at a time
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot0(~seg_sel_out));

endmodule

// ==== verilog/seg_display_top.sv ====
`timescale 1ns/1ps
//################################################
// seven-segment display controller top
// host commands -> credit source -> FIFO -> scanner
//################################################
module seg_display_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int REFRESH_DIV = 50000
) (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic                          cmd_valid,
	input  seg_pkg::seg_op_e              cmd_op,
	input  logic [seg_pkg::DIG_W-1:0]     cmd_digit,
	input  logic [seg_pkg::VAL_W-1:0]     cmd_value,
	output logic                          cmd_ready,
	output logic [7:0]                    seg_val_out,
	output logic [seg_pkg::DIGITS-1:0]    seg_sel_out
);

	// source to FIFO
	logic push;
	logic [seg_pkg::CMD_W-1:0] push_cmd;

	// FIFO to scanner
	logic pop;
	logic [seg_pkg::CMD_W-1:0] pop_cmd;
	logic not_empty;

	// scanner back to source, closes the credit loop
	logic credit_return;

	// credits start at the FIFO depth, so both share one parameter
	seg_cmd_source #(
		.FIFO_DEPTH   (FIFO_DEPTH)
	) seg_cmd_source_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_digit     (cmd_digit),
		.cmd_value     (cmd_value),
		.credit_return (credit_return),
		.cmd_ready     (cmd_ready),
		.push          (push),
		.push_cmd      (push_cmd)
	);

	seg_cmd_fifo #(
		.FIFO_DEPTH   (FIFO_DEPTH)
	) seg_cmd_fifo_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.push          (push),
		.push_cmd      (push_cmd),
		.pop           (pop),
		.pop_cmd       (pop_cmd),
		.not_empty     (not_empty)
	);

	seg_scan_driver #(
		.REFRESH_DIV  (REFRESH_DIV)
	) seg_scan_driver_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.pop_cmd       (pop_cmd),
		.not_empty     (not_empty),
		.pop           (pop),
		.credit_return (credit_return),
		.seg_val_out   (seg_val_out),
		.seg_sel_out   (seg_sel_out)
	);

endmodule

// ==== test/tb_seg_display.sv ====
`timescale 1ns/1ps
//################################################
// testbench for the seven-segment display top
// seeded random host commands, a digit model and
// concurrent assertions against the scan outputs
//################################################
module tb_seg_display;

	localparam int CLK_PERIOD = 40;
	localparam int FIFO_DEPTH = 4;
	localparam int REFRESH_DIV = 4;
	// cycles without an accept before the outputs are compared
	localparam int QUIET_CYCLES = 8;
	// one full pass over all digits
	localparam int SCAN_CYCLES = 8 * REFRESH_DIV;
	localparam int BURST_LEN = 2 * FIFO_DEPTH + 2;
	localparam int RAND_CMDS = 40;
	// hex sweep, random mix, full write, burst, final clear
	localparam int NUM_CMDS = 16 + RAND_CMDS + 8 + BURST_LEN + 1;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + 2000;
	// a credit is away from its push edge to the edge that counts its return
	// so a one per cycle stream only runs dry below three credits
	localparam bit STALL_EXPECTED = (FIFO_DEPTH < 3);

	logic sys_clk;
	logic sys_rst_n;
	logic cmd_valid;
	seg_pkg::seg_op_e cmd_op;
	logic [seg_pkg::DIG_W-1:0] cmd_digit;
	logic [seg_pkg::VAL_W-1:0] cmd_value;
	logic cmd_ready;
	logic [7:0] seg_val_out;
	logic [7:0] seg_sel_out;

	// expected digit state, follows every accepted command
	logic [3:0] model_val [8];
	logic [7:0] model_en;

	// checking window and scenario flags
	int quiet_cnt;
	logic checking;
	logic first_seen;
	logic burst_active;
	logic stall_seen;
	// cycles since each select bit was last low
	int since_low [8];

	integer seed;

	seg_display_top #(
		.FIFO_DEPTH   (FIFO_DEPTH),
		.REFRESH_DIV  (REFRESH_DIV)
	) seg_display_top_inst (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_digit    (cmd_digit),
		.cmd_value    (cmd_value),
		.cmd_ready    (cmd_ready),
		.seg_val_out  (seg_val_out),
		.seg_sel_out  (seg_sel_out)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// report one error and end the run
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	// present one command and hold it until the handshake edge has passed
	task automatic send_cmd(input seg_pkg::seg_op_e op, input logic [2:0] digit,
		input logic [3:0] value);
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_digit = digit;
		cmd_value = value;
		// cmd_ready is settled mid cycle
		@(negedge sys_clk);
		while (!cmd_ready) begin
			@(negedge sys_clk);
		end
		@(posedge sys_clk);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#2;
	endtask

	// long enough to raise checking and then see a whole scan
	task automatic settle();
		idle_cycles(QUIET_CYCLES + SCAN_CYCLES + 4);
	endtask

	// reference model and flags, updated on the handshake edge
	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			model_en <= '0;
			for (int d = 0; d < 8; d++) begin
				model_val[d] <= '0;
				since_low[d] <= 0;
			end
			quiet_cnt <= 0;
			first_seen <= 1'b0;
			stall_seen <= 1'b0;
		end else begin
			if (cmd_valid && cmd_ready) begin
				first_seen <= 1'b1;
				quiet_cnt <= 0;
				case (cmd_op)
					seg_pkg::op_write: begin
						model_val[cmd_digit] <= cmd_value;
						model_en[cmd_digit] <= 1'b1;
					end
					seg_pkg::op_blank: model_en[cmd_digit] <= 1'b0;
					seg_pkg::op_clear_all: begin
						model_en <= '0;
						for (int d = 0; d < 8; d++) begin
							model_val[d] <= '0;
						end
					end
					default: ;
				endcase
			end else if (quiet_cnt < QUIET_CYCLES) begin
				quiet_cnt <= quiet_cnt + 1;
			end
			// host held off during the burst
			if (burst_active && cmd_valid && !cmd_ready) begin
				stall_seen <= 1'b1;
			end
			// scan gap per digit, only counted with everything lit
			for (int d = 0; d < 8; d++) begin
				if (!(checking && model_en == '1) || !seg_sel_out[d]) begin
					since_low[d] <= 0;
				end else begin
					since_low[d] <= since_low[d] + 1;
				end
			end
		end
	end

	assign checking = (quiet_cnt == QUIET_CYCLES);

	// dark and ready out of reset until the first command
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!first_seen |-> (seg_sel_out == 8'hFF) && cmd_ready)
	else abort_run($sformatf("FAILED seg_sel_out=%h cmd_ready=%h before first command",
		$sampled(seg_sel_out), $sampled(cmd_ready)));

	// nothing lit after a clear with no writes since
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		checking && (model_en == '0) |-> (seg_sel_out == 8'hFF))
	else abort_run($sformatf("FAILED seg_sel_out got %h expected ff", $sampled(seg_sel_out)));

	// burst stalls only when the credits are too few
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(burst_active) |-> (stall_seen == STALL_EXPECTED))
	else abort_run($sformatf("FAILED stall_seen got %h expected %h",
		$sampled(stall_seen), STALL_EXPECTED));

	genvar gi;
	generate
		for (gi = 0; gi < 8; gi++) begin : gen_digit_chk
			// a lit select needs an enabled digit
			assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
				checking && !seg_sel_out[gi] |-> model_en[gi])
			else abort_run($sformatf("FAILED seg_sel_out[%0d] low, seg_sel_out=%h model_en=%h",
				gi, $sampled(seg_sel_out), $sampled(model_en)));

			// and shows that digit's pattern
			assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
				checking && !seg_sel_out[gi] |->
				(seg_val_out == seg_pkg::seg_code[model_val[gi]]))
			else abort_run($sformatf("FAILED seg_val_out digit %0d got %h expected %h",
				gi, $sampled(seg_val_out), seg_pkg::seg_code[$sampled(model_val[gi])]));

			// every digit comes round within one scan
			assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
				checking && (model_en == '1) |-> (since_low[gi] < SCAN_CYCLES))
			else abort_run($sformatf("FAILED seg_sel_out[%0d] high for %h cycles",
				gi, $sampled(since_low[gi])));
		end
	endgenerate

	// stimulus
	initial begin
		logic [31:0] rnd;
		seed = 32'h8b6;
		sys_rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = seg_pkg::op_write;
		cmd_digit = '0;
		cmd_value = '0;
		burst_active = 1'b0;
		repeat (5) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;
		// idle display after reset
		idle_cycles(20);

		// every hex value once, two passes over the digits
		for (int k = 0; k < 16; k++) begin
			send_cmd(seg_pkg::op_write, 3'(k), 4'(k));
			if (k % 8 == 7) begin
				settle();
			end
		end

		// random writes with blanks mixed in
		for (int k = 0; k < RAND_CMDS; k++) begin
			rnd = $random(seed);
			if (k == RAND_CMDS / 2) begin
				send_cmd(seg_pkg::op_clear_all, '0, '0);
			end else if (rnd[2:0] < 3'd2) begin
				send_cmd(seg_pkg::op_blank, rnd[6:4], '0);
			end else begin
				send_cmd(seg_pkg::op_write, rnd[6:4], rnd[11:8]);
			end
			idle_cycles(int'(rnd[17:16]));
			if (k % 5 == 4) begin
				settle();
			end
		end

		// all digits lit for the scan coverage check
		for (int k = 0; k < 8; k++) begin
			rnd = $random(seed);
			send_cmd(seg_pkg::op_write, 3'(k), rnd[3:0]);
		end
		settle();

		// back to back burst past the buffer depth
		burst_active = 1'b1;
		for (int k = 0; k < BURST_LEN; k++) begin
			rnd = $random(seed);
			send_cmd(seg_pkg::op_write, rnd[6:4], rnd[11:8]);
		end
		burst_active = 1'b0;
		settle();

		// clear and watch a dark scan
		send_cmd(seg_pkg::op_clear_all, '0, '0);
		settle();

		$display("test passed");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("the run did not finish before the watchdog time ran out");
	end

endmodule

// ==== list.f ====
verilog/seg_pkg.sv
verilog/seg_cmd_source.sv
verilog/seg_cmd_fifo.sv
verilog/seg_scan_driver.sv
verilog/seg_display_top.sv
test/tb_seg_display.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the display controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_seg_display -f list.f

# the log decides the result, so a failing run must not stop the script here
./obj_dir/Vtb_seg_display > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
